// File: source/mem_types_pkg.sv
package mem_types_pkg;

    // bus widths
    localparam int ADDR_WIDTH = 32;
    localparam int WORD_WIDTH = 32;
    localparam int BYTE_WIDTH = 8;
    localparam int LEN_WIDTH  = 3;

    // byte address, wraps at the ram size
    typedef logic [ADDR_WIDTH-1:0] mem_addr_t;

    // full data word as seen by the requesters
    typedef logic [WORD_WIDTH-1:0] mem_word_t;

    // one ram location
    typedef logic [BYTE_WIDTH-1:0] mem_byte_t;

    // access length in bytes, 1, 2 or 4
    typedef logic [LEN_WIDTH-1:0]  mem_len_t;

endpackage

// File: source/mem_ctrl_pkg.sv
package mem_ctrl_pkg;

    // 4 KiB of byte storage, upper address bits are ignored
    localparam int RAM_ADDR_BITS = 12;
    localparam int RAM_BYTES     = 1 << RAM_ADDR_BITS;

    // legal access length codes
    localparam mem_types_pkg::mem_len_t LEN_BYTE = 3'd1;
    localparam mem_types_pkg::mem_len_t LEN_HALF = 3'd2;
    localparam mem_types_pkg::mem_len_t LEN_WORD = 3'd4;

    // controller sequencing
    typedef enum logic [1:0] {
        ST_IDLE,   // waiting for a request
        ST_READ,   // stepping read addresses
        ST_WRITE,  // writing one byte per cycle
        ST_DONE    // ready pulse, requests ignored
    } ctrl_state_t;

endpackage

// File: source/ram_bus_if.sv
`timescale 1ns/1ps

interface ram_bus_if
    import mem_types_pkg::*;
();

    logic      we;     // write strobe
    mem_addr_t addr;   // byte address
    mem_byte_t wdata;
    mem_byte_t rdata;  // registered read data

    modport ctrl (
        output we,
        output addr,
        output wdata,
        input  rdata
    );

    modport ram (
        input  we,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

// File: source/mem_port_ctrl.sv
`timescale 1ns/1ps

module mem_port_ctrl
    import mem_types_pkg::*;
    import mem_ctrl_pkg::*;
(
    input  logic      clock,
    input  logic      reset,

    input  logic      if_read_i,
    input  mem_addr_t if_addr_i,

    input  logic      mem_read_i,
    input  logic      mem_write_i,
    input  mem_addr_t mem_addr_i,
    input  mem_word_t mem_wdata_i,
    input  mem_len_t  mem_length_i,
    input  logic      mem_signed_i,

    output logic      if_busy_o,
    output logic      if_ready_o,
    output mem_word_t if_data_o,

    output logic      mem_busy_o,
    output logic      mem_ready_o,
    output mem_word_t mem_rdata_o,

    ram_bus_if.ctrl   ram
);

    ctrl_state_t state;
    logic        owner_data;  // transfer belongs to the data port
    mem_addr_t   base_addr;
    mem_len_t    length;
    mem_len_t    offset;      // byte offset into the access
    logic [23:0] stage;       // lower bytes of a read, newest on top

    logic        data_req;
    logic        accept;
    logic        read_done;
    logic        write_done;
    logic        sign_bit;
    mem_byte_t   wr_byte;
    mem_word_t   result;

    assign data_req   = mem_read_i | mem_write_i;
    assign accept     = (state == ST_IDLE) && (data_req || if_read_i);
    assign read_done  = (state == ST_READ) && (offset == length);
    assign write_done = (state == ST_WRITE) && (offset == length - 3'd1);

    // ram side, offset ORed into an aligned base
    assign ram.we    = (state == ST_WRITE);
    assign ram.addr  = base_addr | mem_addr_t'(offset);
    assign ram.wdata = wr_byte;

    always_comb begin
        case (offset[1:0])  // little endian byte lanes
            2'd0:    wr_byte = mem_wdata_i[7:0];
            2'd1:    wr_byte = mem_wdata_i[15:8];
            2'd2:    wr_byte = mem_wdata_i[23:16];
            default: wr_byte = mem_wdata_i[31:24];
        endcase
    end

    // last byte comes straight from the ram, it is the top one
    assign sign_bit = mem_signed_i & owner_data & ram.rdata[7];

    always_comb begin
        case (length)
            LEN_BYTE: result = {{24{sign_bit}}, ram.rdata};
            LEN_HALF: result = {{16{sign_bit}}, ram.rdata, stage[23:16]};
            default:  result = {ram.rdata, stage};
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state       <= ST_IDLE;
            owner_data  <= 1'b0;
            offset      <= '0;
            if_busy_o   <= 1'b0;
            if_ready_o  <= 1'b0;
            mem_busy_o  <= 1'b0;
            mem_ready_o <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    offset <= '0;
                    if (data_req) begin  // data port wins
                        owner_data <= 1'b1;
                        mem_busy_o <= 1'b1;
                        state      <= mem_write_i ? ST_WRITE : ST_READ;
                    end else if (if_read_i) begin
                        owner_data <= 1'b0;
                        if_busy_o  <= 1'b1;
                        state      <= ST_READ;
                    end
                end
                ST_READ, ST_WRITE: begin
                    if (read_done || write_done) begin
                        state       <= ST_DONE;
                        if_busy_o   <= 1'b0;
                        mem_busy_o  <= 1'b0;
                        if_ready_o  <= ~owner_data;
                        mem_ready_o <= owner_data;
                    end else begin
                        offset <= offset + 3'd1;
                    end
                end
                default: begin  // ST_DONE, one cycle
                    if_ready_o  <= 1'b0;
                    mem_ready_o <= 1'b0;
                    state       <= ST_IDLE;
                end
            endcase
        end
    end

    // request payload, captured once per access
    always_ff @(posedge clock) begin
        if (accept) begin
            if (data_req) begin
                base_addr <= mem_addr_i;
                length    <= mem_length_i;
            end else begin
                base_addr <= if_addr_i;
                length    <= LEN_WORD;  // fetch is always a word
            end
        end
    end

    // read data returns one cycle behind the address
    always_ff @(posedge clock) begin
        if (state == ST_READ && offset != '0 && !read_done) begin
            stage <= {ram.rdata, stage[23:8]};
        end
    end

    always_ff @(posedge clock) begin
        if (read_done) begin
            if (owner_data) begin
                mem_rdata_o <= result;
            end else begin
                if_data_o <= result;
            end
        end
    end

endmodule

// File: source/byte_ram.sv
`timescale 1ns/1ps

module byte_ram
    import mem_types_pkg::*;
    import mem_ctrl_pkg::*;
(
    input  logic   clock,
    ram_bus_if.ram bus
);

    typedef logic [RAM_ADDR_BITS-1:0] ram_index_t;

    mem_byte_t  mem [RAM_BYTES];
    ram_index_t index;
    mem_byte_t  rdata_q;

    // only the low bits select a location, so addresses wrap
    assign index = bus.addr[RAM_ADDR_BITS-1:0];

    always_ff @(posedge clock) begin
        if (bus.we) begin
            mem[index] <= bus.wdata;
        end
        rdata_q <= mem[index];  // old data on a write
    end

    assign bus.rdata = rdata_q;

endmodule

// File: source/mem_subsystem_top.sv
`timescale 1ns/1ps

module mem_subsystem_top
    import mem_types_pkg::*;
(
    input  logic      clock,
    input  logic      reset,

    input  logic      if_read_i,
    input  mem_addr_t if_addr_i,

    input  logic      mem_read_i,
    input  logic      mem_write_i,
    input  mem_addr_t mem_addr_i,
    input  mem_word_t mem_wdata_i,
    input  mem_len_t  mem_length_i,
    input  logic      mem_signed_i,

    output logic      if_busy_o,
    output logic      if_ready_o,
    output mem_word_t if_data_o,

    output logic      mem_busy_o,
    output logic      mem_ready_o,
    output mem_word_t mem_rdata_o
);

    ram_bus_if ram_bus ();

    mem_port_ctrl ctrl_i (
        .clock        (clock),
        .reset        (reset),
        .if_read_i    (if_read_i),
        .if_addr_i    (if_addr_i),
        .mem_read_i   (mem_read_i),
        .mem_write_i  (mem_write_i),
        .mem_addr_i   (mem_addr_i),
        .mem_wdata_i  (mem_wdata_i),
        .mem_length_i (mem_length_i),
        .mem_signed_i (mem_signed_i),
        .if_busy_o    (if_busy_o),
        .if_ready_o   (if_ready_o),
        .if_data_o    (if_data_o),
        .mem_busy_o   (mem_busy_o),
        .mem_ready_o  (mem_ready_o),
        .mem_rdata_o  (mem_rdata_o),
        .ram          (ram_bus.ctrl)
    );

    byte_ram ram_i (
        .clock (clock),
        .bus   (ram_bus.ram)
    );

endmodule

// File: dv/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
    output logic clock_o,
    output logic reset_o
);

    initial begin
        clock_o = 1'b0;
        forever #10 clock_o = ~clock_o;  // 20 ns period
    end

    initial begin
        reset_o = 1'b1;
        repeat (3) @(posedge clock_o);
        #2 reset_o = 1'b0;  // released on the stimulus offset
    end

endmodule

// File: dv/mem_subsystem_assertions.sv
`timescale 1ns/1ps

module mem_subsystem_assertions
    import mem_types_pkg::*;
    import mem_ctrl_pkg::*;
(
    input logic        clock,
    input logic        reset,
    input ctrl_state_t state,
    input logic        accept,
    input logic        data_req,
    input logic        mem_write_i,
    input mem_len_t    mem_length_i,
    input logic        if_busy_o,
    input logic        if_ready_o,
    input logic        mem_busy_o,
    input logic        mem_ready_o,
    input logic        ram_we
);

    legal_length: assert property (@(posedge clock) disable iff (reset)
        accept && data_req |-> (mem_length_i == LEN_BYTE || mem_length_i == LEN_HALF ||
                                mem_length_i == LEN_WORD))
        else $error("data access accepted with length %0d", mem_length_i);

    mem_ready_pulse: assert property (@(posedge clock) disable iff (reset)
        mem_ready_o |=> !mem_ready_o)
        else $error("mem_ready_o high for more than one cycle");

    if_ready_pulse: assert property (@(posedge clock) disable iff (reset)
        if_ready_o |=> !if_ready_o)
        else $error("if_ready_o high for more than one cycle");

    // ready goes to the port that was busy, never to both
    ready_exclusive: assert property (@(posedge clock) disable iff (reset)
        mem_ready_o |-> !if_ready_o && $past(mem_busy_o))
        else $error("mem_ready_o without a data access or together with if_ready_o");

    if_ready_owner: assert property (@(posedge clock) disable iff (reset)
        if_ready_o |-> $past(if_busy_o))
        else $error("if_ready_o without a fetch in progress");

    // only a data write that is still requested may touch the ram
    we_in_write: assert property (@(posedge clock) disable iff (reset)
        ram_we |-> (state == ST_WRITE && mem_busy_o && mem_write_i))
        else $error("ram write strobe outside a data write");

    // every output settles at the first edge inside reset
    reset_values: assert property (@(posedge clock)
        reset |=> (state == ST_IDLE && !if_busy_o && !mem_busy_o &&
                   !if_ready_o && !mem_ready_o && !ram_we))
        else $error("busy, ready or state not cleared by reset");

endmodule

bind mem_port_ctrl mem_subsystem_assertions assertions_i (
    .clock        (clock),
    .reset        (reset),
    .state        (state),
    .accept       (accept),
    .data_req     (data_req),
    .mem_write_i  (mem_write_i),
    .mem_length_i (mem_length_i),
    .if_busy_o    (if_busy_o),
    .if_ready_o   (if_ready_o),
    .mem_busy_o   (mem_busy_o),
    .mem_ready_o  (mem_ready_o),
    .ram_we       (ram.we)
);

// File: dv/mem_subsystem_tb.sv
`timescale 1ns/1ps

module mem_subsystem_tb
    import mem_types_pkg::*;
    import mem_ctrl_pkg::*;
();

    // under 1000 cycles of traffic, limit leaves a wide margin
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int DRIVE_DELAY    = 2;

    logic      clock;
    logic      reset;
    logic      if_read_i;
    mem_addr_t if_addr_i;
    logic      mem_read_i;
    logic      mem_write_i;
    mem_addr_t mem_addr_i;
    mem_word_t mem_wdata_i;
    mem_len_t  mem_length_i;
    logic      mem_signed_i;
    logic      if_busy_o;
    logic      if_ready_o;
    mem_word_t if_data_o;
    logic      mem_busy_o;
    logic      mem_ready_o;
    mem_word_t mem_rdata_o;

    mem_byte_t model [4096];  // byte image of the ram
    mem_word_t mem_exp_data[$];
    bit        mem_exp_read[$];  // write completions carry no data
    mem_word_t if_exp_data[$];
    mem_addr_t word_addrs [32];
    int        errors;
    int        errors_at_start;
    int        tests_run;
    int        tests_failing;
    int        cycles;
    time       mem_done_time;
    time       if_done_time;

    clock_gen clock_gen_i (
        .clock_o (clock),
        .reset_o (reset)
    );

    mem_subsystem_top dut_i (
        .clock        (clock),
        .reset        (reset),
        .if_read_i    (if_read_i),
        .if_addr_i    (if_addr_i),
        .mem_read_i   (mem_read_i),
        .mem_write_i  (mem_write_i),
        .mem_addr_i   (mem_addr_i),
        .mem_wdata_i  (mem_wdata_i),
        .mem_length_i (mem_length_i),
        .mem_signed_i (mem_signed_i),
        .if_busy_o    (if_busy_o),
        .if_ready_o   (if_ready_o),
        .if_data_o    (if_data_o),
        .mem_busy_o   (mem_busy_o),
        .mem_ready_o  (mem_ready_o),
        .mem_rdata_o  (mem_rdata_o)
    );

    function automatic mem_word_t expected_read(input mem_addr_t addr, input mem_len_t len,
                                                input bit sgn);
        mem_word_t   value;
        int          nbytes;
        logic [11:0] index;
        value  = 32'h0;
        nbytes = int'(len);
        for (int i = 0; i < nbytes; i++) begin
            index = 12'(addr | mem_addr_t'(i));  // aligned base, offset ORed in
            value[8*i +: 8] = model[index];
        end
        if (sgn && value[8*nbytes-1]) begin
            for (int i = nbytes; i < 4; i++) begin
                value[8*i +: 8] = 8'hff;
            end
        end
        return value;
    endfunction

    task automatic model_write(input mem_addr_t addr, input mem_len_t len, input mem_word_t wdata);
        logic [11:0] index;
        for (int i = 0; i < int'(len); i++) begin
            index = 12'(addr | mem_addr_t'(i));
            model[index] = wdata[8*i +: 8];
        end
    endtask

    task automatic report_value(input string name, input mem_word_t got, input mem_word_t exp);
        $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        errors++;
    endtask

    task automatic data_access(input bit is_write, input mem_addr_t addr, input mem_len_t len,
                               input bit sgn, input mem_word_t wdata, input bit timed);
        int edges;
        int expect_edges;
        edges        = -1;
        expect_edges = is_write ? int'(len) : int'(len) + 1;
        mem_exp_read.push_back(!is_write);
        if (is_write) begin
            mem_exp_data.push_back(32'h0);
            model_write(addr, len, wdata);
        end else begin
            mem_exp_data.push_back(expected_read(addr, len, sgn));
        end
        mem_read_i   = !is_write;
        mem_write_i  = is_write;
        mem_addr_i   = addr;
        mem_length_i = len;
        mem_signed_i = sgn;
        mem_wdata_i  = wdata;
        do begin
            @(posedge clock);
            #DRIVE_DELAY;
            edges++;  // first edge is the accepting one
            if (timed && !mem_ready_o && !mem_busy_o) report_value("mem_busy_o", 32'd0, 32'd1);
            if (timed && if_busy_o) report_value("if_busy_o", 32'd1, 32'd0);
            if (timed && if_ready_o) report_value("if_ready_o", 32'd1, 32'd0);
        end while (!mem_ready_o);
        mem_done_time = $time;
        if (timed && edges != expect_edges) begin
            report_value("mem_ready_o latency", mem_word_t'(edges), mem_word_t'(expect_edges));
        end
        mem_read_i  = 1'b0;
        mem_write_i = 1'b0;
        @(posedge clock);  // done state
        #DRIVE_DELAY;
    endtask

    task automatic fetch_access(input mem_addr_t addr, input bit timed);
        int edges;
        edges = -1;
        if_exp_data.push_back(expected_read(addr, LEN_WORD, 1'b0));
        if_read_i = 1'b1;
        if_addr_i = addr;
        do begin
            @(posedge clock);
            #DRIVE_DELAY;
            edges++;
            if (timed && !if_ready_o && !if_busy_o) report_value("if_busy_o", 32'd0, 32'd1);
            if (timed && mem_busy_o) report_value("mem_busy_o", 32'd1, 32'd0);
            if (timed && mem_ready_o) report_value("mem_ready_o", 32'd1, 32'd0);
        end while (!if_ready_o);
        if_done_time = $time;
        if (timed && edges != int'(LEN_WORD) + 1) begin
            report_value("if_ready_o latency", mem_word_t'(edges), mem_word_t'(int'(LEN_WORD) + 1));
        end
        if_read_i = 1'b0;
        @(posedge clock);
        #DRIVE_DELAY;
    endtask

    task automatic finish_test(input string name);
        int test_errors;
        test_errors = errors - errors_at_start;
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d, %s: PASS", tests_run, name);
        end else begin
            $display("test %0d, %s: FAIL with %0d errors", tests_run, name, test_errors);
            tests_failing++;
        end
        errors_at_start = errors;
    endtask

    // ready pulses are checked at the falling edge, away from the drive time
    always @(negedge clock) begin
        if (!reset && mem_ready_o) begin
            if (mem_exp_data.size() == 0) begin
                $display("** Error at %0t: mem_ready_o pulsed with no data access pending", $time);
                errors++;
            end else if (mem_exp_read.pop_front()) begin
                if (mem_rdata_o !== mem_exp_data[0]) begin
                    report_value("mem_rdata_o", mem_rdata_o, mem_exp_data[0]);
                end
                void'(mem_exp_data.pop_front());
            end else begin
                void'(mem_exp_data.pop_front());
            end
        end
        if (!reset && if_ready_o) begin
            if (if_exp_data.size() == 0) begin
                $display("** Error at %0t: if_ready_o pulsed with no fetch pending", $time);
                errors++;
            end else begin
                if (if_data_o !== if_exp_data[0]) begin
                    report_value("if_data_o", if_data_o, if_exp_data[0]);
                end
                void'(if_exp_data.pop_front());
            end
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles, an access never completed", cycles);
            $display("tests failed");
            $finish;
        end
    end

    initial begin : stimulus
        mem_addr_t base;
        mem_word_t ext_words [4];
        if_read_i    = 1'b0;
        if_addr_i    = 32'h0;
        mem_read_i   = 1'b0;
        mem_write_i  = 1'b0;
        mem_addr_i   = 32'h0;
        mem_wdata_i  = 32'h0;
        mem_length_i = LEN_WORD;
        mem_signed_i = 1'b0;
        void'($urandom(61));
        #1;
        wait (reset == 1'b0);

        for (int i = 0; i < 32; i++) begin
            word_addrs[i] = $urandom & 32'hffff_fffc;  // high bits wrap in the ram
            data_access(1'b1, word_addrs[i], LEN_WORD, 1'b0, $urandom, 1'b1);
        end
        for (int i = 0; i < 32; i++) begin
            data_access(1'b0, word_addrs[i], LEN_WORD, 1'b0, 32'h0, 1'b1);
        end
        finish_test("word writes and reads");

        for (int i = 0; i < 8; i++) begin
            base = word_addrs[i];
            data_access(1'b1, base | mem_addr_t'($urandom_range(3, 0)), LEN_BYTE, 1'b0,
                        $urandom, 1'b1);
            data_access(1'b1, base | (mem_addr_t'($urandom_range(1, 0)) << 1), LEN_HALF, 1'b0,
                        $urandom, 1'b1);
            data_access(1'b0, base, LEN_WORD, 1'b0, 32'h0, 1'b1);
        end
        finish_test("narrow writes merge");

        ext_words[0] = 32'h807f_ff01;
        ext_words[1] = 32'h7f80_01fe;
        ext_words[2] = $urandom;
        ext_words[3] = $urandom;
        for (int w = 0; w < 4; w++) begin
            base = 32'h800 + mem_addr_t'(4 * w);
            data_access(1'b1, base, LEN_WORD, 1'b0, ext_words[w], 1'b1);
            for (int off = 0; off < 4; off++) begin
                data_access(1'b0, base | mem_addr_t'(off), LEN_BYTE, 1'b1, 32'h0, 1'b1);
                data_access(1'b0, base | mem_addr_t'(off), LEN_BYTE, 1'b0, 32'h0, 1'b1);
            end
            for (int off = 0; off < 4; off += 2) begin
                data_access(1'b0, base | mem_addr_t'(off), LEN_HALF, 1'b1, 32'h0, 1'b1);
                data_access(1'b0, base | mem_addr_t'(off), LEN_HALF, 1'b0, 32'h0, 1'b1);
            end
        end
        finish_test("load extension");

        for (int i = 0; i < 16; i++) begin
            fetch_access(word_addrs[i], 1'b1);  // also checks the data port stays quiet
        end
        finish_test("instruction fetch");

        fork
            data_access(1'b0, word_addrs[20], LEN_WORD, 1'b0, 32'h0, 1'b1);
            fetch_access(word_addrs[21], 1'b0);
        join
        if (mem_done_time >= if_done_time) begin
            $display("fetch completed before the data read it raced against");
            errors++;
        end
        finish_test("arbitration");

        data_access(1'b0, word_addrs[3], LEN_BYTE, 1'b0, 32'h0, 1'b1);
        data_access(1'b0, word_addrs[3], LEN_HALF, 1'b0, 32'h0, 1'b1);
        data_access(1'b0, word_addrs[3], LEN_WORD, 1'b0, 32'h0, 1'b1);
        data_access(1'b1, word_addrs[4], LEN_BYTE, 1'b0, $urandom, 1'b1);
        data_access(1'b1, word_addrs[4], LEN_HALF, 1'b0, $urandom, 1'b1);
        data_access(1'b1, word_addrs[4], LEN_WORD, 1'b0, $urandom, 1'b1);
        fetch_access(word_addrs[4], 1'b1);
        if (mem_exp_data.size() != 0 || if_exp_data.size() != 0) begin
            $display("accesses left without a ready pulse at the end of the run");
            errors++;
        end
        finish_test("latency");

        $display("%0d tests run, %0d failing, %0d errors", tests_run, tests_failing, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: mem_subsys.f
source/mem_types_pkg.sv
source/mem_ctrl_pkg.sv
source/ram_bus_if.sv
source/mem_port_ctrl.sv
source/byte_ram.sv
source/mem_subsystem_top.sv
dv/clock_gen.sv
dv/mem_subsystem_assertions.sv
dv/mem_subsystem_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the memory subsystem testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=mem_subsystem_sim
LOG_FILE=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module mem_subsystem_tb -f mem_subsys.f \
    --Mdir "$BUILD_DIR" -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "tests failed" "$LOG_FILE"; then
    exit 1
fi
exit 0
